// ==== verilog/dnc_settings.svh ====
// DNC addressing core settings: matrix size, fixed-point format and Wishbone register map
`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

// Matrix geometry
`define DNC_LOCATIONS     8
`define DNC_WORDS         4

// Fixed point, Q8.8 words and unsigned Q1.8 weights
`define DNC_WORD_BITS     16
`define DNC_FRAC_BITS     8
`define DNC_WEIGHT_BITS   9

// Register map, word addresses
`define DNC_WB_ADR_BITS   6
`define DNC_ADR_CTRL      6'h00
`define DNC_ADR_WEIGHT    6'h08
`define DNC_ADR_ERASE     6'h10
`define DNC_ADR_ADD       6'h14
`define DNC_ADR_READ      6'h18
`define DNC_ADR_MATRIX    6'h20

`endif

// ==== verilog/dnc_pkg.sv ====
// DNC addressing core types and the fixed-point weight scaling function
`include "dnc_settings.svh"

package dnc_pkg;

  typedef logic signed [`DNC_WORD_BITS-1:0] word_t;
  typedef logic [`DNC_WEIGHT_BITS-1:0] weight_t;
  typedef logic [$clog2(`DNC_LOCATIONS)-1:0] loc_idx_t;
  typedef logic [$clog2(`DNC_WORDS)-1:0] word_idx_t;

  typedef enum logic {
    MODE_WRITE,
    MODE_READ
  } step_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SWEEP_WRITE,
    ST_SWEEP_READ,
    ST_DRAIN
  } step_state_e;

  // Weight times word, arithmetic shift by the fraction, wrapped to a word
  function automatic word_t scale_word(input weight_t a, input word_t x);
    logic signed [`DNC_WEIGHT_BITS+`DNC_WORD_BITS:0] prod;
    prod = $signed({1'b0, a}) * x;
    return word_t'(prod >>> `DNC_FRAC_BITS);
  endfunction

endpackage

// ==== verilog/dnc_vector_bank.sv ====
// Host-written register bank of a generic payload with a combinational indexed read
`timescale 1ns/10ps

module dnc_vector_bank #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH     = 4
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_idx,
  input  payload_t                 wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_idx,
  output payload_t                 rd_data
);

  payload_t regs [DEPTH];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_data = regs[rd_idx];

endmodule

// ==== verilog/dnc_cell_counter.sv ====
// Cell counter: sweeps location inside word over the whole matrix and flags the final cell
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_cell_counter (
  input  logic               CLK,
  input  logic               RST,
  input  logic               clear,
  input  logic               advance,
  output dnc_pkg::loc_idx_t  loc,
  output dnc_pkg::word_idx_t word,
  output logic               last
);

  import dnc_pkg::*;

  logic last_loc;

  assign last_loc = (loc == loc_idx_t'(`DNC_LOCATIONS - 1));
  assign last     = last_loc && (word == word_idx_t'(`DNC_WORDS - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      loc  <= '0;
      word <= '0;
    end else if (clear) begin
      loc  <= '0;
      word <= '0;
    end else if (advance) begin
      if (last_loc) begin
        // Wraps back to cell (0,0) after the last cell
        loc  <= '0;
        word <= last ? '0 : word + 1'b1;
      end else begin
        loc <= loc + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/dnc_step_fsm.sv ====
// Step FSM: sequences the erase-and-add and read sweeps, then drains the pipelines
`timescale 1ns/10ps

module dnc_step_fsm (
  input  logic                CLK,
  input  logic                RST,
  input  logic                start,
  input  logic                write_req,
  input  logic                read_req,
  input  logic                last,
  output logic                busy,
  output logic                done,
  output logic                advance,
  output logic                clear,
  output logic                cell_valid,
  output dnc_pkg::step_mode_e mode
);

  import dnc_pkg::*;

  step_state_e state;
  logic        pend_read;
  logic        drain_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      pend_read <= 1'b0;
      drain_cnt <= 1'b0;
      done      <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            done      <= 1'b0;
            pend_read <= read_req;
            if (write_req) begin
              state <= ST_SWEEP_WRITE;
            end else if (read_req) begin
              state <= ST_SWEEP_READ;
            end
          end
        end
        ST_SWEEP_WRITE: begin
          // Combined command goes straight into the read sweep
          if (last) begin
            state <= pend_read ? ST_SWEEP_READ : ST_DRAIN;
          end
        end
        ST_SWEEP_READ: begin
          if (last) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          drain_cnt <= ~drain_cnt;
          if (drain_cnt) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign busy       = (state != ST_IDLE);
  assign cell_valid = (state == ST_SWEEP_WRITE) || (state == ST_SWEEP_READ);
  // One cell per sweep cycle, counter held while draining
  assign advance    = cell_valid;
  assign clear      = start;
  assign mode       = (state == ST_SWEEP_READ) ? MODE_READ : MODE_WRITE;

endmodule

// ==== verilog/dnc_memory_matrix.sv ====
// Memory matrix with a two-stage erase-and-add write-back pipeline and a host port
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_memory_matrix (
  input  logic                CLK,
  input  logic                RST,
  // Sweep
  input  logic                cell_valid,
  input  dnc_pkg::step_mode_e mode,
  input  dnc_pkg::loc_idx_t   loc,
  input  dnc_pkg::word_idx_t  word,
  input  dnc_pkg::weight_t    w_j,
  input  dnc_pkg::weight_t    e_k,
  input  dnc_pkg::word_t      v_k,
  // Host
  input  logic                host_we,
  input  dnc_pkg::loc_idx_t   host_loc,
  input  dnc_pkg::word_idx_t  host_word,
  input  dnc_pkg::word_t      host_data,
  // Registered cell word
  output dnc_pkg::word_t      rd_data
);

  import dnc_pkg::*;

  word_t     mem [`DNC_LOCATIONS][`DNC_WORDS];
  loc_idx_t  a_loc;
  word_idx_t a_word;

  // Stage 1 operands
  logic      s1_upd;
  loc_idx_t  s1_loc;
  word_idx_t s1_word;
  weight_t   s1_w;
  weight_t   s1_e;
  word_t     s1_v;

  // Stage 2 result
  weight_t   erase_w;
  word_t     new_word;

  assign a_loc  = cell_valid ? loc : host_loc;
  assign a_word = cell_valid ? word : host_word;

  //////////////////////////////
  // Stage 1: read the cell
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_upd  <= 1'b0;
      rd_data <= '0;
    end else begin
      s1_upd  <= cell_valid && (mode == MODE_WRITE);
      rd_data <= mem[a_loc][a_word];
    end
  end

  always_ff @(posedge CLK) begin
    s1_loc  <= loc;
    s1_word <= word;
    s1_w    <= w_j;
    s1_e    <= e_k;
    s1_v    <= v_k;
  end

  //////////////////////////////
  // Stage 2: erase, add, write back
  //////////////////////////////

  // m - (w*e)*m + w*v, every product rescaled and wrapped
  always_comb begin
    erase_w  = weight_t'(scale_word(s1_w, word_t'(s1_e)));
    new_word = rd_data - scale_word(erase_w, rd_data) + scale_word(s1_w, s1_v);
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int j = 0; j < `DNC_LOCATIONS; j++) begin
        for (int k = 0; k < `DNC_WORDS; k++) begin
          mem[j][k] <= '0;
        end
      end
    end else begin
      // Host writes only land while idle, so never collide with the sweep
      if (host_we) begin
        mem[host_loc][host_word] <= host_data;
      end
      if (s1_upd) begin
        mem[s1_loc][s1_word] <= new_word;
      end
    end
  end

endmodule

// ==== verilog/dnc_read_accumulator.sv ====
// Read accumulator: pipelined weighted sum over locations giving the read vector
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_read_accumulator (
  input  logic                CLK,
  input  logic                RST,
  input  logic                cell_valid,
  input  dnc_pkg::step_mode_e mode,
  input  dnc_pkg::word_idx_t  word,
  input  dnc_pkg::weight_t    w_j,
  input  dnc_pkg::loc_idx_t   loc,
  input  dnc_pkg::word_t      mem_data,
  input  dnc_pkg::word_idx_t  rd_idx,
  output dnc_pkg::word_t      rd_word
);

  import dnc_pkg::*;

  logic      last_loc_of_word;
  logic      s1_valid;
  logic      s1_first;
  logic      s1_last;
  weight_t   s1_w;
  word_idx_t s1_word;
  word_t     acc;
  word_t     sum;
  word_t     r [`DNC_WORDS];

  assign last_loc_of_word = (loc == loc_idx_t'(`DNC_LOCATIONS - 1));

  // Stage 1 lines up with the matrix read register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= cell_valid && (mode == MODE_READ);
    end
  end

  always_ff @(posedge CLK) begin
    s1_w     <= w_j;
    s1_word  <= word;
    s1_first <= (loc == '0);
    s1_last  <= last_loc_of_word;
  end

  // Sum restarts at location 0
  assign sum = (s1_first ? word_t'(0) : acc) + scale_word(s1_w, mem_data);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
      for (int k = 0; k < `DNC_WORDS; k++) begin
        r[k] <= '0;
      end
    end else if (s1_valid) begin
      acc <= sum;
      if (s1_last) begin
        r[s1_word] <= sum;
      end
    end
  end

  assign rd_word = r[rd_idx];

endmodule

// ==== verilog/dnc_wb_regs.sv ====
// Wishbone classic slave for the DNC core: decode, CTRL/status, host strobes, read-back mux
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_wb_regs (
  input  logic                         CLK,
  input  logic                         RST,
  // Wishbone
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`DNC_WB_ADR_BITS-1:0]  wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic                         wb_ack,
  output logic [31:0]                  wb_dat_r,
  // Step control
  input  logic                         busy,
  input  logic                         done,
  output logic                         start,
  output logic                         write_req,
  output logic                         read_req,
  // Vector banks
  output logic                         weight_we,
  output logic                         erase_we,
  output logic                         add_we,
  output logic [2:0]                   host_idx,
  output dnc_pkg::weight_t             host_weight,
  output dnc_pkg::word_t               host_word,
  // Matrix host port
  output logic                         mat_we,
  output dnc_pkg::loc_idx_t            mat_loc,
  output dnc_pkg::word_idx_t           mat_word,
  // Bank read indexes, sweep cell while busy
  input  dnc_pkg::loc_idx_t            sweep_loc,
  input  dnc_pkg::word_idx_t           sweep_word,
  output dnc_pkg::loc_idx_t            weight_idx,
  output dnc_pkg::word_idx_t           vec_idx,
  // Read-back data
  input  dnc_pkg::weight_t             weight_rd,
  input  dnc_pkg::weight_t             erase_rd,
  input  dnc_pkg::word_t               add_rd,
  input  dnc_pkg::word_t               mat_rd,
  input  dnc_pkg::word_t               read_rd
);

  logic req;
  logic wr_ok;
  logic sel_ctrl;
  logic sel_weight;
  logic sel_erase;
  logic sel_add;
  logic sel_read;
  logic sel_matrix;

  //////////////////////////////
  // Decode and handshake
  //////////////////////////////

  // New request, ack low so each access is seen once
  assign req   = wb_cyc & wb_stb & ~wb_ack;
  assign wr_ok = req & wb_we & ~busy;

  assign sel_ctrl   = (wb_adr == `DNC_ADR_CTRL);
  assign sel_weight = ((wb_adr >> 3) == (`DNC_ADR_WEIGHT >> 3));
  assign sel_erase  = ((wb_adr >> 2) == (`DNC_ADR_ERASE >> 2));
  assign sel_add    = ((wb_adr >> 2) == (`DNC_ADR_ADD >> 2));
  assign sel_read   = ((wb_adr >> 2) == (`DNC_ADR_READ >> 2));
  assign sel_matrix = ((wb_adr >> 5) == (`DNC_ADR_MATRIX >> 5));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  //////////////////////////////
  // Write side
  //////////////////////////////

  assign weight_we = wr_ok & sel_weight;
  assign erase_we  = wr_ok & sel_erase;
  assign add_we    = wr_ok & sel_add;
  assign mat_we    = wr_ok & sel_matrix;

  // CTRL bit 0 erase-and-add, bit 1 read
  assign start     = wr_ok & sel_ctrl & (wb_dat_w[0] | wb_dat_w[1]);
  assign write_req = wb_dat_w[0];
  assign read_req  = wb_dat_w[1];

  assign host_idx    = wb_adr[2:0];
  assign host_weight = wb_dat_w[`DNC_WEIGHT_BITS-1:0];
  assign host_word   = wb_dat_w[`DNC_WORD_BITS-1:0];

  // Cell (j,k) sits at matrix base + 4j + k
  assign mat_loc  = wb_adr[4:2];
  assign mat_word = wb_adr[1:0];

  // Banks have one read port, shared by the sweep and the host
  assign weight_idx = busy ? sweep_loc : wb_adr[2:0];
  assign vec_idx    = busy ? sweep_word : wb_adr[1:0];

  //////////////////////////////
  // Read-back mux
  //////////////////////////////

  // Weights zero-extend, signed words sign-extend through the size cast
  always_comb begin
    wb_dat_r = '0;
    if (sel_ctrl) begin
      wb_dat_r = {30'd0, done, busy};
    end else if (sel_weight) begin
      wb_dat_r = 32'(weight_rd);
    end else if (sel_erase) begin
      wb_dat_r = 32'(erase_rd);
    end else if (sel_add) begin
      wb_dat_r = 32'(add_rd);
    end else if (sel_read) begin
      wb_dat_r = 32'(read_rd);
    end else if (sel_matrix) begin
      wb_dat_r = 32'(mat_rd);
    end
  end

endmodule

// ==== verilog/dnc_addressing_top.sv ====
// DNC addressing core top: Wishbone slave, step FSM, cell counter and memory datapath
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_addressing_top (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [`DNC_WB_ADR_BITS-1:0] wb_adr,
  input  logic [31:0]                 wb_dat_w,
  output logic                        wb_ack,
  output logic [31:0]                 wb_dat_r
);

  import dnc_pkg::*;

  //////////////////////////////
  // Wires
  //////////////////////////////

  logic       start, write_req, read_req;
  logic       busy, done, advance, clear, cell_valid, last;
  step_mode_e mode;
  loc_idx_t   loc;
  word_idx_t  word;

  logic       weight_we, erase_we, add_we, mat_we;
  logic [2:0] host_idx;
  weight_t    host_weight;
  word_t      host_word;
  loc_idx_t   mat_loc, weight_idx;
  word_idx_t  mat_word, vec_idx;

  weight_t    w_j, e_k;
  word_t      v_k, mat_rd, read_rd;

  //////////////////////////////
  // Bus and control
  //////////////////////////////

  dnc_wb_regs u_wb_regs (
    .CLK(CLK), .RST(RST),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
    .busy(busy), .done(done), .start(start), .write_req(write_req), .read_req(read_req),
    .weight_we(weight_we), .erase_we(erase_we), .add_we(add_we), .host_idx(host_idx),
    .host_weight(host_weight), .host_word(host_word),
    .mat_we(mat_we), .mat_loc(mat_loc), .mat_word(mat_word),
    .sweep_loc(loc), .sweep_word(word), .weight_idx(weight_idx), .vec_idx(vec_idx),
    .weight_rd(w_j), .erase_rd(e_k), .add_rd(v_k), .mat_rd(mat_rd), .read_rd(read_rd)
  );

  dnc_step_fsm u_step_fsm (
    .CLK(CLK), .RST(RST),
    .start(start), .write_req(write_req), .read_req(read_req), .last(last),
    .busy(busy), .done(done), .advance(advance), .clear(clear),
    .cell_valid(cell_valid), .mode(mode)
  );

  dnc_cell_counter u_cell_counter (
    .CLK(CLK), .RST(RST), .clear(clear), .advance(advance),
    .loc(loc), .word(word), .last(last)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  dnc_vector_bank #(.payload_t(weight_t), .DEPTH(`DNC_LOCATIONS)) u_weight_bank (
    .CLK(CLK), .RST(RST), .we(weight_we), .wr_idx(host_idx), .wr_data(host_weight),
    .rd_idx(weight_idx), .rd_data(w_j)
  );

  dnc_vector_bank #(.payload_t(weight_t), .DEPTH(`DNC_WORDS)) u_erase_bank (
    .CLK(CLK), .RST(RST), .we(erase_we), .wr_idx(host_idx[1:0]), .wr_data(host_weight),
    .rd_idx(vec_idx), .rd_data(e_k)
  );

  dnc_vector_bank #(.payload_t(word_t), .DEPTH(`DNC_WORDS)) u_add_bank (
    .CLK(CLK), .RST(RST), .we(add_we), .wr_idx(host_idx[1:0]), .wr_data(host_word),
    .rd_idx(vec_idx), .rd_data(v_k)
  );

  dnc_memory_matrix u_memory_matrix (
    .CLK(CLK), .RST(RST),
    .cell_valid(cell_valid), .mode(mode), .loc(loc), .word(word),
    .w_j(w_j), .e_k(e_k), .v_k(v_k),
    .host_we(mat_we), .host_loc(mat_loc), .host_word(mat_word), .host_data(host_word),
    .rd_data(mat_rd)
  );

  // Low address bits also select r_k for host reads
  dnc_read_accumulator u_read_accumulator (
    .CLK(CLK), .RST(RST),
    .cell_valid(cell_valid), .mode(mode), .word(word), .w_j(w_j), .loc(loc),
    .mem_data(mat_rd), .rd_idx(mat_word), .rd_word(read_rd)
  );

endmodule

// ==== sim/dnc_addressing_sva.sv ====
// Bound protocol assertions for the DNC core: Wishbone ack pulse and step status
`timescale 1ns/10ps

module dnc_addressing_sva (
  input logic CLK,
  input logic RST,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic busy,
  input logic done
);

  // Single-cycle ack pulse
  ack_pulse: assert property (@(posedge CLK) disable iff (RST) wb_ack |=> !wb_ack)
    else $error("wb_ack stayed high for more than one cycle");

  // Ack answers a request seen one cycle earlier
  ack_after_request: assert property (@(posedge CLK) disable iff (RST)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wb_ack rose without cyc and stb in the previous cycle");

  status_exclusive: assert property (@(posedge CLK) disable iff (RST) !(busy && done))
    else $error("busy and done are high together");

endmodule

bind dnc_addressing_top dnc_addressing_sva u_sva (
  .CLK(CLK),
  .RST(RST),
  .wb_cyc(wb_cyc),
  .wb_stb(wb_stb),
  .wb_ack(wb_ack),
  .busy(busy),
  .done(done)
);

// ==== sim/dnc_addressing_tb.sv ====
// Directed testbench for the DNC addressing core through its Wishbone slave port
`timescale 1ns/10ps
`include "dnc_settings.svh"

module dnc_addressing_tb;

  localparam int ACK_TIMEOUT  = 20;
  localparam int STEP_TIMEOUT = 200;

  logic        CLK;
  logic        RST;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [5:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;

  integer seed;

  // Reference model of the matrix, host vectors and read vector
  logic signed [15:0] ref_m [`DNC_LOCATIONS][`DNC_WORDS];
  logic [8:0]         ref_w [`DNC_LOCATIONS];
  logic [8:0]         ref_e [`DNC_WORDS];
  logic signed [15:0] ref_v [`DNC_WORDS];
  logic signed [15:0] ref_r [`DNC_WORDS];

  dnc_addressing_top u_dut (
    .CLK(CLK),
    .RST(RST),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_we(wb_we),
    .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_ack(wb_ack),
    .wb_dat_r(wb_dat_r)
  );

  always #10 CLK = ~CLK;

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: time %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////
  // Wishbone master
  //////////////////////////////

  task automatic wb_write(input logic [5:0] adr, input logic [31:0] data);
    int cycles;
    @(negedge CLK);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    cycles   = 0;
    @(negedge CLK);
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      cycles++;
      @(negedge CLK);
    end
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack for the write to address 0x%02h", adr);
      abort_run();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [5:0] adr, output logic [31:0] data);
    int cycles;
    @(negedge CLK);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    cycles = 0;
    @(negedge CLK);
    while (!wb_ack && cycles < ACK_TIMEOUT) begin
      cycles++;
      @(negedge CLK);
    end
    if (!wb_ack) begin
      $display("Timeout: no Wishbone ack for the read of address 0x%02h", adr);
      abort_run();
    end
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Unsigned Q1.8 weight times signed word, arithmetic shift by 8, kept to 16 bits
  function automatic logic signed [15:0] scale_ref(input logic [8:0] a,
                                                   input logic signed [15:0] x);
    logic signed [63:0] wa;
    logic signed [63:0] wx;
    logic signed [63:0] prod;
    wa   = {55'd0, a};
    wx   = {{48{x[15]}}, x};
    prod = (wa * wx) >>> 8;
    return prod[15:0];
  endfunction

  function automatic logic [31:0] sext_word(input logic signed [15:0] x);
    return {{16{x[15]}}, x};
  endfunction

  function automatic logic [8:0] rand_weight();
    return 9'($unsigned($random(seed)) % 257);
  endfunction

  task automatic model_erase_add();
    logic signed [15:0] t;
    logic [8:0]         ew;
    int                 j;
    int                 k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      for (k = 0; k < `DNC_WORDS; k++) begin
        t  = scale_ref(ref_w[j], {7'd0, ref_e[k]});
        ew = t[8:0];
        ref_m[j][k] = ref_m[j][k] - scale_ref(ew, ref_m[j][k]) + scale_ref(ref_w[j], ref_v[k]);
      end
    end
  endtask

  task automatic model_read();
    logic signed [15:0] acc;
    int                 j;
    int                 k;
    for (k = 0; k < `DNC_WORDS; k++) begin
      acc = '0;
      for (j = 0; j < `DNC_LOCATIONS; j++) begin
        acc = acc + scale_ref(ref_w[j], ref_m[j][k]);
      end
      ref_r[k] = acc;
    end
  endtask

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Weight mode 0 is all ones, 1 all zero, anything else random
  task automatic load_vectors(input int wmode);
    logic [31:0] data;
    int          j;
    int          k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      case (wmode)
        0:       ref_w[j] = 9'd256;
        1:       ref_w[j] = 9'd0;
        default: ref_w[j] = rand_weight();
      endcase
      wb_write(6'(`DNC_ADR_WEIGHT + j), {23'd0, ref_w[j]});
    end
    for (k = 0; k < `DNC_WORDS; k++) begin
      ref_e[k] = rand_weight();
      wb_write(6'(`DNC_ADR_ERASE + k), {23'd0, ref_e[k]});
      data     = $random(seed);
      ref_v[k] = data[15:0];
      wb_write(6'(`DNC_ADR_ADD + k), data);
    end
  endtask

  task automatic check_matrix();
    logic [31:0] d;
    int          j;
    int          k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      for (k = 0; k < `DNC_WORDS; k++) begin
        wb_read(6'(`DNC_ADR_MATRIX + 4 * j + k), d);
        check_equal($sformatf("matrix cell (%0d,%0d)", j, k), d, sext_word(ref_m[j][k]));
      end
    end
  endtask

  task automatic check_vectors();
    logic [31:0] d;
    int          j;
    int          k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      wb_read(6'(`DNC_ADR_WEIGHT + j), d);
      check_equal($sformatf("weight %0d", j), d, {23'd0, ref_w[j]});
    end
    for (k = 0; k < `DNC_WORDS; k++) begin
      wb_read(6'(`DNC_ADR_ERASE + k), d);
      check_equal($sformatf("erase %0d", k), d, {23'd0, ref_e[k]});
      wb_read(6'(`DNC_ADR_ADD + k), d);
      check_equal($sformatf("add %0d", k), d, sext_word(ref_v[k]));
    end
  endtask

  task automatic check_read_vector();
    logic [31:0] d;
    int          k;
    for (k = 0; k < `DNC_WORDS; k++) begin
      wb_read(6'(`DNC_ADR_READ + k), d);
      check_equal($sformatf("read word %0d", k), d, sext_word(ref_r[k]));
    end
  endtask

  // Busy set and done cleared right after the command
  task automatic start_step(input logic [31:0] cmd);
    logic [31:0] d;
    wb_write(`DNC_ADR_CTRL, cmd);
    wb_read(`DNC_ADR_CTRL, d);
    check_equal("CTRL after start", d, 32'h1);
  endtask

  task automatic wait_step_done();
    logic [31:0] d;
    int          polls;
    polls = 0;
    wb_read(`DNC_ADR_CTRL, d);
    while (d[0] && polls < STEP_TIMEOUT) begin
      polls++;
      wb_read(`DNC_ADR_CTRL, d);
    end
    if (d[0]) begin
      $display("Timeout: step still busy after %0d status polls", polls);
      abort_run();
    end
    check_equal("CTRL after step", d, 32'h2);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic reset_values();
    logic [31:0] d;
    int          j;
    int          k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      ref_w[j] = '0;
      for (k = 0; k < `DNC_WORDS; k++) begin
        ref_m[j][k] = '0;
      end
    end
    for (k = 0; k < `DNC_WORDS; k++) begin
      ref_e[k] = '0;
      ref_v[k] = '0;
      ref_r[k] = '0;
    end
    wb_read(`DNC_ADR_CTRL, d);
    check_equal("CTRL after reset", d, 32'h0);
    check_read_vector();
    check_matrix();
    check_vectors();
  endtask

  task automatic host_access();
    logic [31:0] data;
    int          j;
    int          k;
    for (j = 0; j < `DNC_LOCATIONS; j++) begin
      for (k = 0; k < `DNC_WORDS; k++) begin
        data        = $random(seed);
        ref_m[j][k] = data[15:0];
        wb_write(6'(`DNC_ADR_MATRIX + 4 * j + k), data);
      end
      data     = $random(seed);
      ref_w[j] = data[8:0];
      wb_write(6'(`DNC_ADR_WEIGHT + j), data);
    end
    for (k = 0; k < `DNC_WORDS; k++) begin
      data     = $random(seed);
      ref_e[k] = data[8:0];
      wb_write(6'(`DNC_ADR_ERASE + k), data);
      data     = $random(seed);
      ref_v[k] = data[15:0];
      wb_write(6'(`DNC_ADR_ADD + k), data);
    end
    check_matrix();
    check_vectors();
  endtask

  // Full, zero and random weights in turn
  task automatic erase_and_add();
    int wmode;
    for (wmode = 0; wmode < 3; wmode++) begin
      load_vectors(wmode);
      start_step(32'h1);
      wait_step_done();
      model_erase_add();
      check_matrix();
    end
  endtask

  task automatic read_step();
    load_vectors(2);
    start_step(32'h2);
    wait_step_done();
    model_read();
    check_read_vector();
    check_matrix();
  endtask

  task automatic combined_and_busy();
    logic [31:0] d;
    int          k;
    load_vectors(2);
    start_step(32'h3);
    // Host writes that land while the core is busy
    wb_write(6'(`DNC_ADR_MATRIX + 9), 32'h0000_1234);
    wb_write(6'(`DNC_ADR_WEIGHT + 3), 32'h0000_0055);
    for (k = 0; k < `DNC_WORDS; k++) begin
      wb_write(6'(`DNC_ADR_ADD + k), 32'h0000_7777);
    end
    wb_read(`DNC_ADR_CTRL, d);
    check_equal("CTRL during combined step", d, 32'h1);
    wait_step_done();
    model_erase_add();
    model_read();
    check_read_vector();
    check_matrix();
    check_vectors();
  endtask

  initial begin
    CLK      = 1'b0;
    RST      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 16;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    reset_values();
    host_access();
    erase_and_add();
    read_step();
    combined_and_busy();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/dnc_pkg.sv
verilog/dnc_vector_bank.sv
verilog/dnc_cell_counter.sv
verilog/dnc_step_fsm.sv
verilog/dnc_memory_matrix.sv
verilog/dnc_read_accumulator.sv
verilog/dnc_wb_regs.sv
verilog/dnc_addressing_top.sv
sim/dnc_addressing_sva.sv
sim/dnc_addressing_tb.sv
